// File: flist.f
+incdir+.
iqTypesPkg.sv
recoveryPkg.sv
iqIfs.sv
entryFreeList.sv
payloadRam.sv
flushDetector.sv
returnSweepCounter.sv
recoverySequencer.sv
issueQueue.sv
issueQueueTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the issue queue testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module issueQueueTb -o issueQueueSim
./obj_dir/issueQueueSim | tee sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi

// File: issueQueueTb.sv
// Self-checking testbench for the issue queue allocator and payload store
// Applies a table of steps in a loop against a model of the free list order,
// the payload words and the per-entry ownership table

`timescale 1ns/1ps

`include "iq_cfg.svh"

module issueQueueTb;
    import iqTypesPkg::*;
    import recoveryPkg::*;

    localparam int entryNum = `IQ_ENTRY_NUM;
    localparam int retWidth = `IQ_RETURN_WIDTH;
    localparam int alMask = `AL_ENTRY_NUM - 1;

    localparam int opAlloc = 0;
    localparam int opRead = 1;
    localparam int opSelect = 2;
    localparam int opRelease = 3;
    localparam int opRwRecover = 4;
    localparam int opCommitRecover = 5;

    logic clk;
    logic rstN;
    logic allocate;
    logic allocatable;
    iqIndexT allocatedPtr;
    iqCountT freeCount;
    logic write;
    iqIndexT writePtr;
    payloadT writeData;
    alPtrT writeAlPtr;
    iqIndexT readPtr;
    payloadT readData;
    logic releaseEntry;
    iqIndexT releasePtr;
    iqIndexT selectedPtr;
    alPtrT selectedAlPtr;
    logic recover;
    logic recoverFromRw;
    logic flushAll;
    alPtrT flushHead;
    alPtrT flushTail;
    logic [entryNum-1:0] flushVector;
    logic returning;

    // Step table, one row per step
    int tblOp [$];
    int tblArg [$];
    int tblExp [$];

    // Reference model
    int freeQ [$];
    bit occ [entryNum];
    int alMod [entryNum];
    bit isMemMod [entryNum];
    payloadT payMod [entryNum];
    int fld [entryNum][4];

    int checks = 0;
    int errors = 0;
    int cycleCnt = 0;
    int cycleLimit = 1000;

    issueQueue i_issueQueue (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            $display("Timeout after %0d cycles, the step table did not complete", cycleCnt);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic addStep(input int op, input int arg, input int exp);
        tblOp.push_back(op);
        tblArg.push_back(arg);
        tblExp.push_back(exp);
    endtask

    // Move to the drive point of the next cycle
    task automatic nextEdge();
        @(posedge clk);
        #1;
    endtask

    task automatic clearStrobes();
        allocate = 1'b0;
        write = 1'b0;
        releaseEntry = 1'b0;
        recover = 1'b0;
        recoverFromRw = 1'b0;
        flushAll = 1'b0;
    endtask

    // Circular distance test with head inclusive and tail exclusive
    function automatic bit inRangeRef(int ptr, int head, int tail);
        return ((ptr - head) & alMask) < ((tail - head) & alMask);
    endfunction

    function automatic string opName(int op);
        case (op)
            opAlloc: return "allocate";
            opRead: return "read";
            opSelect: return "select";
            opRelease: return "release";
            opRwRecover: return "read-stage recovery";
            default: return "commit recovery";
        endcase
    endfunction

    // Random fields packed into the payload layout with the kind bit on top
    task automatic buildPayload(input int idx, input bit mem, output payloadT word);
        isMemMod[idx] = mem;
        fld[idx][0] = int'($urandom_range(0, mem ? 1 : (1 << opcodeBits) - 1));
        fld[idx][1] = int'($urandom_range(0, (1 << regBits) - 1));
        if (mem) begin
            fld[idx][2] = int'($urandom_range(0, (1 << offsetBits) - 1));
            fld[idx][3] = 0;
            word = {1'b1, 1'(fld[idx][0]), regBits'(fld[idx][1]), offsetBits'(fld[idx][2])};
        end else begin
            fld[idx][2] = int'($urandom_range(0, (1 << regBits) - 1));
            fld[idx][3] = int'($urandom_range(0, (1 << regBits) - 1));
            word = {1'b0, opcodeBits'(fld[idx][0]), regBits'(fld[idx][1]),
                    regBits'(fld[idx][2]), regBits'(fld[idx][3])};
        end
        payMod[idx] = word;
    endtask

    task automatic checkRead(input int idx);
        check("readData", 32'(readData), 32'(payMod[idx]));
        if (isMemMod[idx]) begin
            check("readData.memOp.isMem", 32'(readData.memOp.isMem), 32'd1);
            check("readData.memOp.isStore", 32'(readData.memOp.isStore), 32'(fld[idx][0]));
            check("readData.memOp.base", 32'(readData.memOp.base), 32'(fld[idx][1]));
            check("readData.memOp.offset", 32'(readData.memOp.offset), 32'(fld[idx][2]));
        end else begin
            check("readData.intOp.isMem", 32'(readData.intOp.isMem), 32'd0);
            check("readData.intOp.opcode", 32'(readData.intOp.opcode), 32'(fld[idx][0]));
            check("readData.intOp.dst", 32'(readData.intOp.dst), 32'(fld[idx][1]));
            check("readData.intOp.srcA", 32'(readData.intOp.srcA), 32'(fld[idx][2]));
            check("readData.intOp.srcB", 32'(readData.intOp.srcB), 32'(fld[idx][3]));
        end
    endtask

    task automatic runRecovery(input bit fromRw, input bit all);
        int headI;
        int tailI;
        int k;
        logic [entryNum-1:0] expVec;
        headI = int'($urandom_range(0, alMask));
        tailI = int'($urandom_range(0, alMask));
        recover = 1'b1;
        recoverFromRw = fromRw;
        flushAll = all;
        flushHead = alPtrT'(headI);
        flushTail = alPtrT'(tailI);
        #1;
        for (int i = 0; i < entryNum; i++) begin
            expVec[i] = occ[i] && (all || inRangeRef(alMod[i], headI, tailI));
        end
        check("flushVector", 32'(flushVector), 32'(expVec));
        nextEdge();
        for (int i = 0; i < entryNum; i++) begin
            if (expVec[i]) begin
                occ[i] = 1'b0;
            end
        end
        clearStrobes();
        k = 0;
        #1;
        while (returning === 1'b1 && k < 4 * entryNum) begin
            if (fromRw) begin
                check("freeCount", 32'(freeCount), 32'(freeQ.size()));
            end else begin
                check("allocatable", 32'(allocatable), 32'd0);
            end
            nextEdge();
            // Sweep cycle k hands back entries k*W to k*W+W-1 in lane order
            for (int j = 0; j < retWidth && fromRw; j++) begin
                if (expVec[k * retWidth + j]) begin
                    freeQ.push_back(k * retWidth + j);
                end
            end
            k++;
            #1;
        end
        check("returning cycles", 32'(k),
              fromRw ? 32'(entryNum / retWidth) : 32'(`IQ_RESET_CYCLE));
        if (!fromRw) begin
            freeQ.delete();
            for (int i = 0; i < entryNum; i++) begin
                freeQ.push_back(i);
            end
        end
        nextEdge();
    endtask

    task automatic runStep(input int s);
        int op;
        int arg;
        int idx;
        bit avail;
        payloadT word;
        alPtrT al;
        op = tblOp[s];
        arg = tblArg[s];
        clearStrobes();
        case (op)
            opAlloc: begin
                avail = freeQ.size() > 0;
                allocate = 1'b1;
                if (avail) begin
                    idx = freeQ[0];
                    buildPayload(idx, arg[0], word);
                    al = alPtrT'($urandom_range(0, alMask));
                    write = 1'b1;
                    writePtr = iqIndexT'(idx);
                    writeData = word;
                    writeAlPtr = al;
                end
                #1;
                check("returning", 32'(returning), 32'd0);
                check("allocatable", 32'(allocatable), 32'(avail));
                check("freeCount", 32'(freeCount), 32'(freeQ.size()));
                if (avail) begin
                    check("allocatedPtr", 32'(allocatedPtr),
                          tblExp[s] >= 0 ? 32'(tblExp[s]) : 32'(idx));
                end
                nextEdge();
                if (avail) begin
                    void'(freeQ.pop_front());
                    occ[idx] = 1'b1;
                    alMod[idx] = int'(al);
                end
            end
            opRead: begin
                readPtr = iqIndexT'(arg);
                #1;
                checkRead(arg);
                nextEdge();
            end
            opSelect: begin
                selectedPtr = iqIndexT'(arg);
                #1;
                check("selectedAlPtr", 32'(selectedAlPtr), 32'(alMod[arg]));
                nextEdge();
            end
            opRelease: begin
                releaseEntry = 1'b1;
                releasePtr = iqIndexT'(arg);
                #1;
                check("freeCount", 32'(freeCount), 32'(freeQ.size()));
                nextEdge();
                freeQ.push_back(arg);
                occ[arg] = 1'b0;
            end
            opRwRecover: runRecovery(1'b1, arg[0]);
            default: runRecovery(1'b0, 1'b1);
        endcase
    endtask

    task automatic buildTable();
        // Fresh list hands out 0..7 and then ignores one allocate on empty
        for (int i = 0; i < entryNum; i++) begin
            addStep(opAlloc, i % 2, i);
        end
        addStep(opAlloc, 0, -1);
        for (int i = 0; i < entryNum; i++) begin
            addStep(opRead, i, -1);
            addStep(opSelect, i, -1);
        end
        // Release order comes back as allocation order
        addStep(opRelease, 5, -1);
        addStep(opRelease, 2, -1);
        addStep(opRelease, 6, -1);
        addStep(opAlloc, 1, 5);
        addStep(opAlloc, 0, 2);
        addStep(opAlloc, 1, 6);
        addStep(opRelease, 1, -1);
        addStep(opRelease, 3, -1);
        addStep(opRelease, 7, -1);
        // Selective flush with random ranges
        addStep(opRwRecover, 0, -1);
        for (int i = 0; i < entryNum; i++) begin
            addStep(opAlloc, i % 2, -1);
            addStep(opSelect, i, -1);
        end
        addStep(opRwRecover, 0, -1);
        addStep(opRwRecover, 1, -1);
        for (int i = 0; i < entryNum; i++) begin
            addStep(opRead, i, -1);
        end
        // Commit-time refill restores ascending order
        addStep(opCommitRecover, 0, -1);
        for (int i = 0; i < entryNum; i++) begin
            addStep(opAlloc, (i + 1) % 2, i);
        end
        addStep(opAlloc, 0, -1);
        for (int i = 0; i < entryNum; i++) begin
            addStep(opRead, i, -1);
        end
    endtask

    initial begin
        void'($urandom(32'hd9002e1b));
        clk = 1'b0;
        rstN = 1'b0;
        clearStrobes();
        writePtr = '0;
        writeData = '0;
        writeAlPtr = '0;
        readPtr = '0;
        releasePtr = '0;
        selectedPtr = '0;
        flushHead = '0;
        flushTail = '0;
        for (int i = 0; i < entryNum; i++) begin
            freeQ.push_back(i);
            occ[i] = 1'b0;
            alMod[i] = 0;
        end
        buildTable();
        cycleLimit = 4 * tblOp.size() + 100;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int s = 0; s < tblOp.size(); s++) begin
            runStep(s);
            $display("Step %0d %s done, %0d errors so far", s, opName(tblOp[s]), errors);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: issueQueue.sv
// Top level of the issue queue allocator and payload store
// Dispatch allocates and writes entries, issue releases them, recovery
// flushes entries by active-list range and hands them back to the free list

`timescale 1ns/1ps

`include "iq_cfg.svh"

module issueQueue (
    input logic clk,
    input logic rstN,
    input logic allocate,
    output logic allocatable,
    output iqTypesPkg::iqIndexT allocatedPtr,
    output iqTypesPkg::iqCountT freeCount,
    input logic write,
    input iqTypesPkg::iqIndexT writePtr,
    input iqTypesPkg::payloadT writeData,
    input recoveryPkg::alPtrT writeAlPtr,
    input iqTypesPkg::iqIndexT readPtr,
    output iqTypesPkg::payloadT readData,
    input logic releaseEntry,
    input iqTypesPkg::iqIndexT releasePtr,
    input iqTypesPkg::iqIndexT selectedPtr,
    output recoveryPkg::alPtrT selectedAlPtr,
    input logic recover,
    input logic recoverFromRw,
    input logic flushAll,
    input recoveryPkg::alPtrT flushHead,
    input recoveryPkg::alPtrT flushTail,
    output logic [`IQ_ENTRY_NUM-1:0] flushVector,
    output logic returning
);
    freeListIf flIf ();
    returnIf swIf ();

    // Blocked while the free list refills
    assign allocatable = !flIf.init && (flIf.count != '0);
    assign freeCount = flIf.count;

    entryFreeList u_entryFreeList (
        .clk(clk),
        .rstN(rstN),
        .allocate(allocate),
        .allocatedPtr(allocatedPtr),
        .releaseEntry(releaseEntry),
        .releasePtr(releasePtr),
        .fl(flIf.freeList)
    );

    payloadRam u_payloadRam (
        .clk(clk),
        .write(write),
        .writePtr(writePtr),
        .writeData(writeData),
        .readPtr(readPtr),
        .readData(readData)
    );

    flushDetector u_flushDetector (
        .clk(clk),
        .rstN(rstN),
        .write(write),
        .writePtr(writePtr),
        .writeAlPtr(writeAlPtr),
        .releaseEntry(releaseEntry),
        .releasePtr(releasePtr),
        .recover(recover),
        .flushAll(flushAll),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .selectedPtr(selectedPtr),
        .selectedAlPtr(selectedAlPtr),
        .flushVector(flushVector)
    );

    recoverySequencer u_recoverySequencer (
        .clk(clk),
        .rstN(rstN),
        .recover(recover),
        .recoverFromRw(recoverFromRw),
        .flushVector(flushVector),
        .returning(returning),
        .fl(flIf.sequencer),
        .sweep(swIf.sequencer)
    );

    returnSweepCounter u_returnSweepCounter (
        .clk(clk),
        .rstN(rstN),
        .sw(swIf.counter)
    );

endmodule

// File: recoverySequencer.sv
// Recovery FSM of the issue queue allocator
// Commit-time recovery re-initializes the free list, read-stage recovery
// keeps the flush vector and sweeps it back into the free list

`timescale 1ns/1ps

`include "iq_cfg.svh"

module recoverySequencer (
    input logic clk,
    input logic rstN,
    input logic recover,
    input logic recoverFromRw,
    input logic [`IQ_ENTRY_NUM-1:0] flushVector,
    output logic returning,
    freeListIf.sequencer fl,
    returnIf.sequencer sweep
);
    import iqTypesPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stReinit,
        stSweep
    } stateT;

    stateT state;
    logic [`IQ_ENTRY_NUM-1:0] savedFlush;

    // A new recovery restarts from any state
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
        end else if (recover) begin
            state <= recoverFromRw ? stSweep : stReinit;
        end else if (state != stIdle && sweep.last) begin
            state <= stIdle;
        end
    end

    always_ff @(posedge clk) begin
        if (recover && recoverFromRw) begin
            savedFlush <= flushVector;
        end
    end

    always_comb begin
        iqIndexT lanePtr;
        sweep.start = recover;
        case (state)
            stReinit: sweep.phaseLen = iqCountT'(`IQ_RESET_CYCLE);
            stSweep:  sweep.phaseLen = iqCountT'(`IQ_ENTRY_NUM / `IQ_RETURN_WIDTH);
            default:  sweep.phaseLen = iqCountT'(1);
        endcase
        fl.init = (state == stReinit);
        for (int i = 0; i < `IQ_RETURN_WIDTH; i++) begin
            lanePtr = iqIndexT'(sweep.offset + i);
            fl.retPtr[i] = lanePtr;
            fl.retPush[i] = (state == stSweep) && savedFlush[lanePtr];
        end
        returning = (state != stIdle);
    end

    assert property (@(posedge clk) disable iff (!rstN)
        !(fl.init && (|fl.retPush)));

endmodule

// File: returnSweepCounter.sv
// Cycle counter shared by both recovery sequences
// Cleared by start, stops on the last cycle of the phase

`timescale 1ns/1ps

`include "iq_cfg.svh"

module returnSweepCounter (
    input logic clk,
    input logic rstN,
    returnIf.counter sw
);
    import iqTypesPkg::*;

    iqCountT cycleCnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cycleCnt <= '0;
        end else if (sw.start) begin
            cycleCnt <= '0;
        end else if (!sw.last) begin
            cycleCnt <= cycleCnt + 1'b1;
        end
    end

    always_comb begin
        sw.last = (iqCountT'(cycleCnt + 1'b1) >= sw.phaseLen);
        // First entry index covered by this cycle's return lanes
        sw.offset = iqIndexT'(cycleCnt * `IQ_RETURN_WIDTH);
    end

endmodule

// File: flushDetector.sv
// Ownership table holding the active-list pointer and occupied bit per entry
// Produces the flush vector for a recovery and the pointer of the selected entry

`timescale 1ns/1ps

`include "iq_cfg.svh"

module flushDetector (
    input logic clk,
    input logic rstN,
    input logic write,
    input iqTypesPkg::iqIndexT writePtr,
    input recoveryPkg::alPtrT writeAlPtr,
    input logic releaseEntry,
    input iqTypesPkg::iqIndexT releasePtr,
    input logic recover,
    input logic flushAll,
    input recoveryPkg::alPtrT flushHead,
    input recoveryPkg::alPtrT flushTail,
    input iqTypesPkg::iqIndexT selectedPtr,
    output recoveryPkg::alPtrT selectedAlPtr,
    output logic [`IQ_ENTRY_NUM-1:0] flushVector
);
    import iqTypesPkg::*;
    import recoveryPkg::*;

    alPtrT alPtrReg [`IQ_ENTRY_NUM];
    logic [`IQ_ENTRY_NUM-1:0] occupied;

    always_ff @(posedge clk) begin
        if (write) begin
            alPtrReg[writePtr] <= writeAlPtr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            occupied <= '0;
        end else begin
            occupied <= (occupied
                & ~(`IQ_ENTRY_NUM'(releaseEntry) << releasePtr)
                | (`IQ_ENTRY_NUM'(write) << writePtr))
                & ~flushVector;
        end
    end

    always_comb begin
        for (int i = 0; i < `IQ_ENTRY_NUM; i++) begin
            flushVector[i] = recover && occupied[i]
                && (flushAll || inFlushRange(alPtrReg[i], flushHead, flushTail));
        end
        // Entry dispatched this cycle is judged on its incoming pointer
        if (write) begin
            flushVector[writePtr] = recover
                && (flushAll || inFlushRange(writeAlPtr, flushHead, flushTail));
        end
    end

    // For squashing wakeups of flushed ops
    assign selectedAlPtr = alPtrReg[selectedPtr];

endmodule

// File: payloadRam.sv
// Payload store of the issue queue, one word per entry
// Written at dispatch, read combinationally by select in the same cycle as the pointer

`timescale 1ns/1ps

`include "iq_cfg.svh"

module payloadRam (
    input logic clk,
    input logic write,
    input iqTypesPkg::iqIndexT writePtr,
    input iqTypesPkg::payloadT writeData,
    input iqTypesPkg::iqIndexT readPtr,
    output iqTypesPkg::payloadT readData
);
    import iqTypesPkg::*;

    payloadT mem [`IQ_ENTRY_NUM];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[writePtr] <= writeData;
        end
    end

    // No read latency
    assign readData = mem[readPtr];

    // Select needs a known kind bit in every written word to pick its view
    assert property (@(posedge clk)
        write |-> !$isunknown(writeData.memOp.isMem));

endmodule

// File: entryFreeList.sv
// Circular FIFO of free issue queue entry indices
// One pop per cycle for dispatch; release and return lanes push in lane order
// init from the sequencer refills it with 0..N-1 like a reset

`timescale 1ns/1ps

`include "iq_cfg.svh"

module entryFreeList (
    input logic clk,
    input logic rstN,
    input logic allocate,
    output iqTypesPkg::iqIndexT allocatedPtr,
    input logic releaseEntry,
    input iqTypesPkg::iqIndexT releasePtr,
    freeListIf.freeList fl
);
    import iqTypesPkg::*;

    // Ordinary release on lane 0, recovery returns after it
    localparam int pushLanes = 1 + `IQ_RETURN_WIDTH;

    iqIndexT mem [`IQ_ENTRY_NUM];
    iqIndexT head;
    iqIndexT tail;
    iqCountT count;
    logic doPop;
    logic [pushLanes-1:0] pushEn;
    iqIndexT pushData [pushLanes];
    iqIndexT pushSlot [pushLanes];
    iqCountT pushCnt;

    always_comb begin
        doPop = allocate && !fl.init && (count != '0);
        pushEn[0] = releaseEntry;
        pushData[0] = releasePtr;
        for (int i = 0; i < `IQ_RETURN_WIDTH; i++) begin
            pushEn[i+1] = fl.retPush[i];
            pushData[i+1] = fl.retPtr[i];
        end
        // Compact active lanes onto consecutive tail slots
        pushCnt = '0;
        for (int i = 0; i < pushLanes; i++) begin
            pushSlot[i] = iqIndexT'(tail + pushCnt);
            pushCnt = pushCnt + iqCountT'(pushEn[i]);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            head <= '0;
            tail <= '0;
            count <= iqCountT'(`IQ_ENTRY_NUM);
            for (int i = 0; i < `IQ_ENTRY_NUM; i++) begin
                mem[i] <= iqIndexT'(i);
            end
        end else if (fl.init) begin
            head <= '0;
            tail <= '0;
            count <= iqCountT'(`IQ_ENTRY_NUM);
            for (int i = 0; i < `IQ_ENTRY_NUM; i++) begin
                mem[i] <= iqIndexT'(i);
            end
        end else begin
            for (int i = 0; i < pushLanes; i++) begin
                if (pushEn[i]) begin
                    mem[pushSlot[i]] <= pushData[i];
                end
            end
            if (doPop) begin
                head <= iqIndexT'(head + 1'b1);
            end
            tail <= iqIndexT'(tail + pushCnt);
            count <= count + pushCnt - iqCountT'(doPop);
        end
    end

    assign allocatedPtr = mem[head];
    assign fl.count = count;

    // An empty list has its head caught up with the tail
    assert property (@(posedge clk) disable iff (!rstN)
        (count == '0) |-> (head == tail));

    // Returns and releases never push more entries than exist
    assert property (@(posedge clk) disable iff (!rstN)
        count <= iqCountT'(`IQ_ENTRY_NUM));

endmodule

// File: iqIfs.sv
// Interfaces between the recovery sequencer and its two helpers
// freeListIf carries re-init and return pushes, returnIf runs the sweep counter

`timescale 1ns/1ps

`include "iq_cfg.svh"

interface freeListIf;
    import iqTypesPkg::*;

    logic init;
    logic [`IQ_RETURN_WIDTH-1:0] retPush;
    iqIndexT retPtr [`IQ_RETURN_WIDTH];
    iqCountT count;

    modport sequencer (
        output init,
        output retPush,
        output retPtr
    );

    modport freeList (
        input init,
        input retPush,
        input retPtr,
        output count
    );
endinterface

interface returnIf;
    import iqTypesPkg::*;

    // Phase control from the sequencer
    logic start;
    iqCountT phaseLen;

    // Progress back from the counter
    iqIndexT offset;
    logic last;

    modport sequencer (
        output start,
        output phaseLen,
        input offset,
        input last
    );

    modport counter (
        input start,
        input phaseLen,
        output offset,
        output last
    );
endinterface

// File: recoveryPkg.sv
// Active-list pointer type and the selective flush range check
// Used by the ownership table to decide which entries a recovery squashes

`include "iq_cfg.svh"

package recoveryPkg;

    typedef logic [$clog2(`AL_ENTRY_NUM)-1:0] alPtrT;

    // Circular half-open range [head, tail); empty when head equals tail
    function automatic logic inFlushRange(alPtrT ptr, alPtrT head, alPtrT tail);
        logic hit;
        if (head == tail) begin
            hit = 1'b0;
        end else if (head < tail) begin
            hit = (ptr >= head) && (ptr < tail);
        end else begin
            // Range wraps past the last active-list slot
            hit = (ptr >= head) || (ptr < tail);
        end
        return hit;
    endfunction

endpackage

// File: iqTypesPkg.sv
// Entry index, count and payload types of the issue queue
// The payload word is stored once and read either as an integer or a memory op

`include "iq_cfg.svh"

package iqTypesPkg;

    typedef logic [$clog2(`IQ_ENTRY_NUM)-1:0] iqIndexT;
    typedef logic [$clog2(`IQ_ENTRY_NUM):0] iqCountT;

    localparam int regBits = 5;
    localparam int opcodeBits = `IQ_PAYLOAD_BITS - 1 - 3 * regBits;
    localparam int offsetBits = `IQ_PAYLOAD_BITS - 2 - regBits;

    // Kind bit on top, 0 for integer ops
    typedef struct packed {
        logic isMem;
        logic [opcodeBits-1:0] opcode;
        logic [regBits-1:0] dst;
        logic [regBits-1:0] srcA;
        logic [regBits-1:0] srcB;
    } intPayloadT;

    // Kind bit on top, 1 for memory ops
    typedef struct packed {
        logic isMem;
        logic isStore;
        logic [regBits-1:0] base;
        logic [offsetBits-1:0] offset;
    } memPayloadT;

    // Reader picks the view from the shared kind bit
    typedef union packed {
        intPayloadT intOp;
        memPayloadT memOp;
    } payloadT;

endpackage

// File: iq_cfg.svh
// Size and sequence-length macros for the issue queue allocator
// Include in any package or module that sizes its storage from them

`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// Number of issue queue entries, a power of two
`define IQ_ENTRY_NUM 8

// Indices pushed back to the free list per sweep cycle
`define IQ_RETURN_WIDTH 2

// Cycles spent re-initializing the free list on commit-time recovery
`define IQ_RESET_CYCLE 4

// Active list depth
`define AL_ENTRY_NUM 16

// Width of one payload word
`define IQ_PAYLOAD_BITS 24

`endif
